// File: rtl/rv_ex_pkg.sv
// shared types and constants of the RV32I execute stage; fixed 32-bit datapath, no loads/stores/CSRs
package rv_ex_pkg;

  ////////////////////////////////////////////////////////////
  // word types
  ////////////////////////////////////////////////////////////

  // data or address word
  typedef logic [31:0] word_t;
  // register file index
  typedef logic [4:0]  reg_addr_t;
  // raw instruction word
  typedef logic [31:0] instr_t;

  ////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////

  // alu operators, cut down to the RV32I set
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLTS,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LTS,
    ALU_GES,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // instruction class, steers write-back and redirect
  // CLS_LUI covers AUIPC as well
  typedef enum logic [2:0] {
    CLS_NONE,
    CLS_ALU,
    CLS_LUI,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR
  } ex_class_e;

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // size of one instruction in bytes
  localparam word_t PC_STEP = 32'd4;

  ////////////////////////////////////////////////////////////
  // output structs
  ////////////////////////////////////////////////////////////

  // register write-back, 38 bits
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

  // pc redirect, 33 bits
  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

endpackage

// File: rtl/rv_alu.sv
// combinational RV32I alu; shift amount is operand b[4:0], clk and reset are not used inside
`timescale 1ns/10ps

module rv_alu
(
  input  logic               clk,
  input  logic               rst_n_i,

  input  rv_ex_pkg::alu_op_e operator_i,
  input  rv_ex_pkg::word_t   operand_a_i,
  input  rv_ex_pkg::word_t   operand_b_i,

  output rv_ex_pkg::word_t   adder_result_o,
  output rv_ex_pkg::word_t   result_o,
  output logic               comparison_result_o
);

  ////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////

  logic             adder_op_b_negate;
  rv_ex_pkg::word_t operand_b_neg;
  rv_ex_pkg::word_t adder_in_b;
  rv_ex_pkg::word_t adder_result;

  // two's complement of b, used by sub and every compare
  assign operand_b_neg = (~operand_b_i) + 32'd1;

  always_comb
  begin
    adder_op_b_negate = 1'b0;
    case (operator_i)
      rv_ex_pkg::ALU_SUB,
      rv_ex_pkg::ALU_SLTS, rv_ex_pkg::ALU_SLTU,
      rv_ex_pkg::ALU_EQ,   rv_ex_pkg::ALU_NE,
      rv_ex_pkg::ALU_LTS,  rv_ex_pkg::ALU_GES,
      rv_ex_pkg::ALU_LTU,  rv_ex_pkg::ALU_GEU: adder_op_b_negate = 1'b1;
      default: adder_op_b_negate = 1'b0;
    endcase
  end

  assign adder_in_b   = adder_op_b_negate ? operand_b_neg : operand_b_i;
  // single adder shared by add, sub, compares and the jalr sum
  assign adder_result = operand_a_i + adder_in_b;

  assign adder_result_o = adder_result;

  ////////////////////////////////////////////////////////////
  // shifter
  ////////////////////////////////////////////////////////////

  logic             shift_left;
  logic             shift_arithmetic;
  rv_ex_pkg::word_t operand_a_rev;
  rv_ex_pkg::word_t shift_op_a;
  logic [32:0]      shift_op_a_33;
  logic [32:0]      shift_right_full;
  rv_ex_pkg::word_t shift_right_result;
  rv_ex_pkg::word_t shift_left_result;
  rv_ex_pkg::word_t shift_result;

  assign shift_left       = (operator_i == rv_ex_pkg::ALU_SLL);
  assign shift_arithmetic = (operator_i == rv_ex_pkg::ALU_SRA);

  // left shift = reverse, shift right, reverse again
  for (genvar k = 0; k < 32; k++)
  begin : g_rev_in
    assign operand_a_rev[k] = operand_a_i[31-k];
  end

  assign shift_op_a = shift_left ? operand_a_rev : operand_a_i;

  // extra top bit carries the sign only for sra, zero otherwise
  assign shift_op_a_33    = {shift_arithmetic & shift_op_a[31], shift_op_a};
  assign shift_right_full = $signed(shift_op_a_33) >>> operand_b_i[4:0];

  assign shift_right_result = shift_right_full[31:0];

  for (genvar j = 0; j < 32; j++)
  begin : g_rev_out
    assign shift_left_result[j] = shift_right_result[31-j];
  end

  assign shift_result = shift_left ? shift_left_result : shift_right_result;

  ////////////////////////////////////////////////////////////
  // comparator
  ////////////////////////////////////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_greater_equal;
  logic cmp_result;

  assign cmp_signed = (operator_i == rv_ex_pkg::ALU_SLTS) ||
                      (operator_i == rv_ex_pkg::ALU_LTS)  ||
                      (operator_i == rv_ex_pkg::ALU_GES);

  // a - b == 0
  assign is_equal = (adder_result == 32'd0);

  // same sign: difference sign decides
  // different sign: a's msb decides, inverted for signed compares
  always_comb
  begin
    if (operand_a_i[31] == operand_b_i[31])
      is_greater_equal = ~adder_result[31];
    else
      is_greater_equal = operand_a_i[31] ^ cmp_signed;
  end

  always_comb
  begin
    case (operator_i)
      rv_ex_pkg::ALU_EQ:  cmp_result = is_equal;
      rv_ex_pkg::ALU_NE:  cmp_result = ~is_equal;
      rv_ex_pkg::ALU_GES,
      rv_ex_pkg::ALU_GEU: cmp_result = is_greater_equal;
      rv_ex_pkg::ALU_LTS, rv_ex_pkg::ALU_SLTS,
      rv_ex_pkg::ALU_LTU, rv_ex_pkg::ALU_SLTU: cmp_result = ~is_greater_equal;
      default:            cmp_result = 1'b0;
    endcase
  end

  assign comparison_result_o = cmp_result;

  ////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (operator_i)
      rv_ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      rv_ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      rv_ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      rv_ex_pkg::ALU_ADD,
      rv_ex_pkg::ALU_SUB: result_o = adder_result;
      rv_ex_pkg::ALU_SLL,
      rv_ex_pkg::ALU_SRL,
      rv_ex_pkg::ALU_SRA: result_o = shift_result;
      // compare bit, zero extended
      default:            result_o = {31'd0, cmp_result};
    endcase
  end

endmodule

// File: rtl/rv_ex_decoder.sv
// combinational decode of OP/OP-IMM/LUI/AUIPC/BRANCH/JAL/JALR; anything else, incl. bad funct3, is CLS_NONE
`timescale 1ns/10ps

module rv_ex_decoder
(
  input  rv_ex_pkg::instr_t    instr_i,
  input  rv_ex_pkg::word_t     pc_i,
  input  rv_ex_pkg::word_t     rs1_data_i,
  input  rv_ex_pkg::word_t     rs2_data_i,

  output rv_ex_pkg::alu_op_e   alu_op_o,
  output rv_ex_pkg::word_t     alu_a_o,
  output rv_ex_pkg::word_t     alu_b_o,
  output rv_ex_pkg::word_t     imm_o,
  output rv_ex_pkg::reg_addr_t rd_o,
  output rv_ex_pkg::ex_class_e ex_class_o
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic               funct7_b5;
  rv_ex_pkg::word_t   imm_i_type;
  rv_ex_pkg::word_t   imm_u_type;
  rv_ex_pkg::word_t   imm_b_type;
  rv_ex_pkg::word_t   imm_j_type;
  rv_ex_pkg::alu_op_e arith_op;
  rv_ex_pkg::alu_op_e branch_op;

  ////////////////////////////////////////////////////////////
  // fields and immediates
  ////////////////////////////////////////////////////////////

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7_b5 = instr_i[30];
  assign rd_o      = instr_i[11:7];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'd0};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // operator maps
  ////////////////////////////////////////////////////////////

  // funct3 of OP and OP-IMM
  // sub only exists in OP, the immediate form has no subtract
  always_comb
  begin
    case (funct3)
      3'b000:  arith_op = (funct7_b5 && opcode == rv_ex_pkg::OPC_OP) ?
                          rv_ex_pkg::ALU_SUB : rv_ex_pkg::ALU_ADD;
      3'b001:  arith_op = rv_ex_pkg::ALU_SLL;
      3'b010:  arith_op = rv_ex_pkg::ALU_SLTS;
      3'b011:  arith_op = rv_ex_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_ex_pkg::ALU_XOR;
      // srai shares bit 30 with sra
      3'b101:  arith_op = funct7_b5 ? rv_ex_pkg::ALU_SRA : rv_ex_pkg::ALU_SRL;
      3'b110:  arith_op = rv_ex_pkg::ALU_OR;
      default: arith_op = rv_ex_pkg::ALU_AND;
    endcase
  end

  // funct3 of BRANCH, 010 and 011 are reserved
  always_comb
  begin
    case (funct3)
      3'b000:  branch_op = rv_ex_pkg::ALU_EQ;
      3'b001:  branch_op = rv_ex_pkg::ALU_NE;
      3'b100:  branch_op = rv_ex_pkg::ALU_LTS;
      3'b101:  branch_op = rv_ex_pkg::ALU_GES;
      3'b110:  branch_op = rv_ex_pkg::ALU_LTU;
      default: branch_op = rv_ex_pkg::ALU_GEU;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // operand select and class
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    alu_op_o   = rv_ex_pkg::ALU_ADD;
    alu_a_o    = rs1_data_i;
    alu_b_o    = rs2_data_i;
    imm_o      = 32'd0;
    ex_class_o = rv_ex_pkg::CLS_NONE;
    case (opcode)
      rv_ex_pkg::OPC_OP:
      begin
        alu_op_o   = arith_op;
        ex_class_o = rv_ex_pkg::CLS_ALU;
      end
      rv_ex_pkg::OPC_OP_IMM:
      begin
        alu_op_o   = arith_op;
        alu_b_o    = imm_i_type;
        imm_o      = imm_i_type;
        ex_class_o = rv_ex_pkg::CLS_ALU;
      end
      rv_ex_pkg::OPC_LUI:
      begin
        // 0 + imm through the add path
        alu_a_o    = 32'd0;
        alu_b_o    = imm_u_type;
        imm_o      = imm_u_type;
        ex_class_o = rv_ex_pkg::CLS_LUI;
      end
      rv_ex_pkg::OPC_AUIPC:
      begin
        alu_a_o    = pc_i;
        alu_b_o    = imm_u_type;
        imm_o      = imm_u_type;
        ex_class_o = rv_ex_pkg::CLS_LUI;
      end
      rv_ex_pkg::OPC_BRANCH:
      begin
        // rs1 vs rs2 compare, target is formed in the branch unit
        alu_op_o   = branch_op;
        imm_o      = imm_b_type;
        ex_class_o = (funct3[2:1] == 2'b01) ? rv_ex_pkg::CLS_NONE : rv_ex_pkg::CLS_BRANCH;
      end
      rv_ex_pkg::OPC_JAL:
      begin
        alu_a_o    = pc_i;
        alu_b_o    = imm_j_type;
        imm_o      = imm_j_type;
        ex_class_o = rv_ex_pkg::CLS_JAL;
      end
      rv_ex_pkg::OPC_JALR:
      begin
        // rs1 + imm on the shared adder gives the jump target
        alu_b_o    = imm_i_type;
        imm_o      = imm_i_type;
        ex_class_o = rv_ex_pkg::CLS_JALR;
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/rv_branch_unit.sv
// redirect decision and targets; no misaligned-target trap, bit 1 of a target is passed as is
`timescale 1ns/10ps

module rv_branch_unit
(
  input  rv_ex_pkg::ex_class_e ex_class_i,
  input  rv_ex_pkg::word_t     pc_i,
  input  rv_ex_pkg::word_t     imm_i,
  input  logic                 cmp_taken_i,
  input  rv_ex_pkg::word_t     jalr_sum_i,

  output logic                 redirect_req_o,
  output rv_ex_pkg::word_t     redirect_target_o,
  output rv_ex_pkg::word_t     link_addr_o
);

  rv_ex_pkg::word_t pc_rel_target;

  // dedicated pc-relative adder for branches and jal
  assign pc_rel_target = pc_i + imm_i;

  // return address of jal/jalr
  assign link_addr_o = pc_i + rv_ex_pkg::PC_STEP;

  // jumps always leave the sequential path, branches only when taken
  assign redirect_req_o = (ex_class_i == rv_ex_pkg::CLS_JAL)  ||
                          (ex_class_i == rv_ex_pkg::CLS_JALR) ||
                          ((ex_class_i == rv_ex_pkg::CLS_BRANCH) && cmp_taken_i);

  // jalr clears bit 0 of rs1 + imm
  assign redirect_target_o = (ex_class_i == rv_ex_pkg::CLS_JALR) ?
                             {jalr_sum_i[31:1], 1'b0} : pc_rel_target;

endmodule

// File: rtl/rv_ex_retire.sv
// output register of the execute stage; one result per cycle, no back-pressure, consumer must keep up
`timescale 1ns/10ps

module rv_ex_retire
(
  input  logic                 clk,
  input  logic                 rst_n_i,

  input  logic                 instr_valid_i,
  input  rv_ex_pkg::ex_class_e ex_class_i,
  input  rv_ex_pkg::reg_addr_t rd_i,
  input  rv_ex_pkg::word_t     alu_result_i,
  input  rv_ex_pkg::word_t     link_addr_i,
  input  logic                 redirect_req_i,
  input  rv_ex_pkg::word_t     redirect_target_i,

  output rv_ex_pkg::wb_t       wb_o,
  output rv_ex_pkg::redirect_t redirect_o
);

  logic                 is_jump;
  logic                 writes_rd;
  rv_ex_pkg::wb_t       wb_next;
  rv_ex_pkg::redirect_t redirect_next;

  assign is_jump = (ex_class_i == rv_ex_pkg::CLS_JAL) ||
                   (ex_class_i == rv_ex_pkg::CLS_JALR);

  // classes that write a register, branches and unknown ones do not
  assign writes_rd = (ex_class_i == rv_ex_pkg::CLS_ALU) ||
                     (ex_class_i == rv_ex_pkg::CLS_LUI) || is_jump;

  always_comb
  begin
    // x0 writes are dropped here, jumps to x0 still redirect
    wb_next.valid = instr_valid_i && writes_rd && (rd_i != 5'd0);
    wb_next.rd    = rd_i;
    wb_next.data  = is_jump ? link_addr_i : alu_result_i;

    redirect_next.valid  = instr_valid_i && redirect_req_i;
    redirect_next.target = redirect_target_i;
  end

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      wb_o       <= '0;
      redirect_o <= '0;
    end
    else
    begin
      wb_o       <= wb_next;
      redirect_o <= redirect_next;
    end
  end

endmodule

// File: rtl/rv_ex_stage.sv
// RV32I execute stage top; one-cycle latency, operands arrive already read and forwarded
`timescale 1ns/10ps

module rv_ex_stage
(
  input  logic                 clk,
  input  logic                 rst_n_i,

  input  logic                 instr_valid_i,
  input  rv_ex_pkg::instr_t    instr_i,
  input  rv_ex_pkg::word_t     pc_i,
  input  rv_ex_pkg::word_t     rs1_data_i,
  input  rv_ex_pkg::word_t     rs2_data_i,

  output rv_ex_pkg::wb_t       wb_o,
  output rv_ex_pkg::redirect_t redirect_o
);

  rv_ex_pkg::alu_op_e   alu_op;
  rv_ex_pkg::word_t     alu_a;
  rv_ex_pkg::word_t     alu_b;
  rv_ex_pkg::word_t     imm;
  rv_ex_pkg::reg_addr_t rd;
  rv_ex_pkg::ex_class_e ex_class;
  rv_ex_pkg::word_t     alu_result;
  rv_ex_pkg::word_t     adder_result;
  logic                 comparison_result;
  logic                 redirect_req;
  rv_ex_pkg::word_t     redirect_target;
  rv_ex_pkg::word_t     link_addr;

  // decode, all combinational
  rv_ex_decoder rv_ex_decoder_inst (
    .instr_i    (instr_i),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .alu_op_o   (alu_op),
    .alu_a_o    (alu_a),
    .alu_b_o    (alu_b),
    .imm_o      (imm),
    .rd_o       (rd),
    .ex_class_o (ex_class)
  );

  rv_alu rv_alu_inst (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .operator_i          (alu_op),
    .operand_a_i         (alu_a),
    .operand_b_i         (alu_b),
    .adder_result_o      (adder_result),
    .result_o            (alu_result),
    .comparison_result_o (comparison_result)
  );

  // adder result doubles as the jalr sum
  rv_branch_unit rv_branch_unit_inst (
    .ex_class_i        (ex_class),
    .pc_i              (pc_i),
    .imm_i             (imm),
    .cmp_taken_i       (comparison_result),
    .jalr_sum_i        (adder_result),
    .redirect_req_o    (redirect_req),
    .redirect_target_o (redirect_target),
    .link_addr_o       (link_addr)
  );

  // the only sequential part of the stage
  rv_ex_retire rv_ex_retire_inst (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .instr_valid_i     (instr_valid_i),
    .ex_class_i        (ex_class),
    .rd_i              (rd),
    .alu_result_i      (alu_result),
    .link_addr_i       (link_addr),
    .redirect_req_i    (redirect_req),
    .redirect_target_i (redirect_target),
    .wb_o              (wb_o),
    .redirect_o        (redirect_o)
  );

endmodule

// File: sim/rv_ex_checker.sv
// compares rv_ex_stage outputs one cycle after each expectation; payload checked only where valid
`timescale 1ns/10ps

module rv_ex_checker
(
  input  logic                 clk,
  input  rv_ex_pkg::instr_t    instr_i,
  input  rv_ex_pkg::wb_t       wb_i,
  input  rv_ex_pkg::redirect_t redirect_i,

  input  logic                 exp_push_i,
  input  logic                 exp_full_i,
  input  int                   exp_id_i,
  input  rv_ex_pkg::wb_t       exp_wb_i,
  input  rv_ex_pkg::redirect_t exp_redirect_i,

  output int                   checked_count_o,
  output int                   failed_count_o,
  output int                   error_count_o,
  output int                   compared_count_o
);

  // one pending expectation per accepted cycle
  typedef struct packed {
    logic                 is_test;
    logic                 full;
    logic [31:0]          id;
    rv_ex_pkg::instr_t    instr;
    rv_ex_pkg::wb_t       wb;
    rv_ex_pkg::redirect_t redirect;
  } expect_t;

  expect_t pending[$];
  expect_t incoming;
  expect_t cur;
  int      errors_before;

  initial
  begin
    checked_count_o  = 0;
    failed_count_o   = 0;
    error_count_o    = 0;
    compared_count_o = 0;
  end

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED at %0t ns: %s expected %h, actual %h",
               $time, name, expected, actual);
      error_count_o = error_count_o + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // capture at the edge where the dut samples its inputs
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (exp_push_i)
    begin
      incoming.is_test  = (exp_id_i >= 0);
      incoming.full     = exp_full_i;
      incoming.id       = exp_id_i;
      incoming.instr    = instr_i;
      incoming.wb       = exp_wb_i;
      incoming.redirect = exp_redirect_i;
      pending.push_back(incoming);
    end
  end

  ////////////////////////////////////////////////////////////
  // compare half a cycle later when registered outputs have settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (pending.size() != 0)
    begin
      cur           = pending.pop_front();
      errors_before = error_count_o;
      compare_field("wb_o.valid", 32'(cur.wb.valid), 32'(wb_i.valid));
      compare_field("redirect_o.valid", 32'(cur.redirect.valid), 32'(redirect_i.valid));
      // reset check also wants cleared data and target
      if (cur.full || cur.wb.valid)
      begin
        compare_field("wb_o.rd", 32'(cur.wb.rd), 32'(wb_i.rd));
        compare_field("wb_o.data", cur.wb.data, wb_i.data);
      end
      if (cur.full || cur.redirect.valid)
        compare_field("redirect_o.target", cur.redirect.target, redirect_i.target);
      if (cur.is_test)
      begin
        checked_count_o = checked_count_o + 1;
        if (error_count_o != errors_before)
          failed_count_o = failed_count_o + 1;
        if (cur.id == 0)
          $display("test 0 reset: %s", (error_count_o == errors_before) ? "ok" : "wrong");
        else
          $display("test %0d instr %h: %s", cur.id, cur.instr,
                   (error_count_o == errors_before) ? "ok" : "wrong");
      end
      compared_count_o = compared_count_o + 1;
    end
  end

endmodule

// File: sim/tb_rv_ex_stage.sv
// testbench for rv_ex_stage; run from the project root, reads sim/rv_ex_trace.txt, needs --timing
`timescale 1ns/10ps

module tb_rv_ex_stage;

  ////////////////////////////////////////////////////////////
  // dut and checker signals
  ////////////////////////////////////////////////////////////

  logic                 clk;
  logic                 rst_n_i;
  logic                 instr_valid_i;
  rv_ex_pkg::instr_t    instr_i;
  rv_ex_pkg::word_t     pc_i;
  rv_ex_pkg::word_t     rs1_data_i;
  rv_ex_pkg::word_t     rs2_data_i;
  rv_ex_pkg::wb_t       wb_o;
  rv_ex_pkg::redirect_t redirect_o;

  // expectation for this cycle
  // the checker takes it at the rising edge
  logic                 exp_push;
  logic                 exp_full;
  int                   exp_id;
  rv_ex_pkg::wb_t       exp_wb;
  rv_ex_pkg::redirect_t exp_redirect;

  int                   checked_count;
  int                   failed_count;
  int                   error_count;
  int                   compared_count;
  int                   pushed_count;

  // trace contents with one entry per test
  rv_ex_pkg::instr_t    trace_instr[$];
  rv_ex_pkg::word_t     trace_pc[$];
  rv_ex_pkg::word_t     trace_rs1[$];
  rv_ex_pkg::word_t     trace_rs2[$];
  rv_ex_pkg::wb_t       trace_wb[$];
  rv_ex_pkg::redirect_t trace_redirect[$];
  logic                 trace_bad;

  int                   cycle_count;
  int                   cycle_limit;
  int                   gap;

  rv_ex_stage rv_ex_stage_inst (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .wb_o          (wb_o),
    .redirect_o    (redirect_o)
  );

  rv_ex_checker rv_ex_checker_inst (
    .clk              (clk),
    .instr_i          (instr_i),
    .wb_i             (wb_o),
    .redirect_i       (redirect_o),
    .exp_push_i       (exp_push),
    .exp_full_i       (exp_full),
    .exp_id_i         (exp_id),
    .exp_wb_i         (exp_wb),
    .exp_redirect_i   (exp_redirect),
    .checked_count_o  (checked_count),
    .failed_count_o   (failed_count),
    .error_count_o    (error_count),
    .compared_count_o (compared_count)
  );

  // 4 ns period
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // limit grows with the trace and allows up to 2 idle cycles per test
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // trace reader
  ////////////////////////////////////////////////////////////

  task automatic read_trace();
    int                   fd;
    int                   n;
    string                line;
    logic [31:0]          f_instr, f_pc, f_rs1, f_rs2;
    logic [31:0]          f_wbv, f_rd, f_data, f_rv, f_tgt;
    rv_ex_pkg::wb_t       wb_entry;
    rv_ex_pkg::redirect_t redirect_entry;
    fd = $fopen("sim/rv_ex_trace.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the trace file sim/rv_ex_trace.txt");
      trace_bad = 1'b1;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      if ($fgets(line, fd) == 0)
        continue;
      // skip comments and blank lines
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
        continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  f_instr, f_pc, f_rs1, f_rs2, f_wbv, f_rd, f_data, f_rv, f_tgt);
      if (n != 9)
      begin
        $display("malformed trace line, only %0d fields: %s", n, line);
        trace_bad = 1'b1;
        continue;
      end
      wb_entry.valid        = f_wbv[0];
      wb_entry.rd           = f_rd[4:0];
      wb_entry.data         = f_data;
      redirect_entry.valid  = f_rv[0];
      redirect_entry.target = f_tgt;
      trace_instr.push_back(f_instr);
      trace_pc.push_back(f_pc);
      trace_rs1.push_back(f_rs1);
      trace_rs2.push_back(f_rs2);
      trace_wb.push_back(wb_entry);
      trace_redirect.push_back(redirect_entry);
    end
    $fclose(fd);
    if (trace_instr.size() == 0)
    begin
      $display("the trace file holds no tests");
      trace_bad = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // every task starts and ends 1 ns after a rising edge

  // 10 reset cycles
  // the last one also checks the cleared outputs
  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (9) @(posedge clk);
    #1;
    exp_push     = 1'b1;
    exp_full     = 1'b1;
    exp_id       = 0;
    exp_wb       = '0;
    exp_redirect = '0;
    pushed_count = pushed_count + 1;
    @(posedge clk);
    #1;
    rst_n_i  = 1'b1;
    exp_push = 1'b0;
  endtask

  task automatic drive_test(input int idx);
    instr_valid_i = 1'b1;
    instr_i       = trace_instr[idx];
    pc_i          = trace_pc[idx];
    rs1_data_i    = trace_rs1[idx];
    rs2_data_i    = trace_rs2[idx];
    exp_push      = 1'b1;
    exp_full      = 1'b0;
    exp_id        = idx + 1;
    exp_wb        = trace_wb[idx];
    exp_redirect  = trace_redirect[idx];
    pushed_count  = pushed_count + 1;
    @(posedge clk);
    #1;
  endtask

  // instruction bus keeps its last value and only valid drops
  task automatic idle_cycle();
    instr_valid_i = 1'b0;
    exp_push      = 1'b1;
    exp_full      = 1'b0;
    exp_id        = -1;
    exp_wb        = '0;
    exp_redirect  = '0;
    pushed_count  = pushed_count + 1;
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(74));
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    rs1_data_i    = '0;
    rs2_data_i    = '0;
    exp_push      = 1'b0;
    exp_full      = 1'b0;
    exp_id        = -1;
    exp_wb        = '0;
    exp_redirect  = '0;
    trace_bad     = 1'b0;
    cycle_count   = 0;
    pushed_count  = 0;
    read_trace();
    cycle_limit   = 20 + 4 * trace_instr.size();
    apply_reset();
    for (int i = 0; i < trace_instr.size(); i++)
    begin
      gap = $urandom % 3;
      repeat (gap) idle_cycle();
      drive_test(i);
    end
    // both valids must drop once the stream ends
    idle_cycle();
    exp_push = 1'b0;
    // every expectation handed over must come back compared
    while (compared_count < pushed_count)
      @(posedge clk);
    $display("tests checked %0d, tests failed %0d, mismatches %0d",
             checked_count, failed_count, error_count);
    if (!trace_bad && error_count == 0 && failed_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: sim/rv_ex_trace.txt
# columns: instr pc rs1 rs2 | wb_valid wb_rd wb_data | redirect_valid redirect_target
# all hex; rd, data and target are ignored where their valid is 0
002081B3 00000100 12345678 0FEDCBA8 1 03 22222220 0 00000000
402081B3 00000104 00000003 00000005 1 03 FFFFFFFE 0 00000000
0020F1B3 00000108 F0F0F0F0 FF00FF00 1 03 F000F000 0 00000000
0020E1B3 0000010C F0F0F0F0 FF00FF00 1 03 FFF0FFF0 0 00000000
0020C1B3 00000110 F0F0F0F0 FF00FF00 1 03 0FF00FF0 0 00000000
002091B3 00000114 00000003 0000003F 1 03 80000000 0 00000000
0020D1B3 00000118 80000000 00000000 1 03 80000000 0 00000000
4020D1B3 0000011C 80000000 0000001F 1 03 FFFFFFFF 0 00000000
0020A1B3 00000120 80000000 00000001 1 03 00000001 0 00000000
0020B1B3 00000124 80000000 00000001 1 03 00000000 0 00000000
FFF08193 00000128 00000000 DEADBEEF 1 03 FFFFFFFF 0 00000000
0010A193 0000012C FFFFFFFF 00000000 1 03 00000001 0 00000000
FFF0B193 00000130 00000005 00000000 1 03 00000001 0 00000000
0FF0C193 00000134 12345678 00000000 1 03 12345687 0 00000000
01F09193 00000138 00000001 00000000 1 03 80000000 0 00000000
4040D193 0000013C 80000010 00000000 1 03 F8000001 0 00000000
00208863 00001000 80000000 80000000 0 00 00000000 1 00001010
FE209CE3 00001000 80000000 7FFFFFFF 0 00 00000000 1 00000FF8
0020C863 00001000 80000000 00000001 0 00 00000000 1 00001010
0020C863 00001000 00000001 80000000 0 00 00000000 0 00000000
0020D863 00001000 00000005 00000005 0 00 00000000 1 00001010
0020E863 00001000 00000001 80000000 0 00 00000000 1 00001010
0020F863 00001000 80000000 00000001 0 00 00000000 1 00001010
0020F863 00001000 00000000 FFFFFFFF 0 00 00000000 0 00000000
100000EF 00002000 00000000 00000000 1 01 00002004 1 00002100
FFDFF06F 00002000 00000000 00000000 0 00 00000000 1 00001FFC
003082E7 00003000 00004000 00000000 1 05 00003004 1 00004002
FFF082E7 00003010 00004001 00000000 1 05 00003014 1 00004000
123453B7 00000200 FFFFFFFF FFFFFFFF 1 07 12345000 0 00000000
80000417 00000010 00000000 00000000 1 08 80000010 0 00000000
00208033 00000300 00000001 00000002 0 00 00000000 0 00000000
0000A183 00000304 00000001 00000002 0 00 00000000 0 00000000
00000073 00000308 00000000 00000000 0 00 00000000 0 00000000

// File: tb.f
rtl/rv_ex_pkg.sv
rtl/rv_alu.sv
rtl/rv_ex_decoder.sv
rtl/rv_branch_unit.sv
rtl/rv_ex_retire.sv
rtl/rv_ex_stage.sv
sim/rv_ex_checker.sv
sim/tb_rv_ex_stage.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_rv_ex_stage
RTL_TOP  = rv_ex_stage
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
SOURCES  = $(wildcard rtl/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --top-module $(RTL_TOP) rtl/rv_ex_pkg.sv rtl/rv_alu.sv \
		rtl/rv_ex_decoder.sv rtl/rv_branch_unit.sv rtl/rv_ex_retire.sv rtl/rv_ex_stage.sv

clean:
	rm -rf $(BUILD) $(LOG)
